/* flist.f */
hw/board_pkg.sv
hw/board_ctrl.sv
hw/audio_mixer.sv
hw/frame_fifo.sv
hw/i2s_serializer.sv
hw/track_display.sv
hw/de2_glue_top.sv
test/tb_de2_glue_asserts.sv
test/tb_de2_glue.sv

/* test/tb_de2_glue.sv */
`timescale 1ns/1ps

module tb_de2_glue;
  import board_pkg::*;

  localparam int CLK_HALF      = 5;                              // 10 ns clock
  localparam int RESET_CYCLES  = 3;
  localparam int FRAME_CYCLES  = FRAME_BITS * BCLK_DIV;          // One codec frame
  localparam int NUM_TESTS     = 7;
  localparam int MAX_FRAMES    = 16;                             // Longest test, frames
  localparam int WATCHDOG_CYC  = NUM_TESTS * MAX_FRAMES * FRAME_CYCLES * 2;
  localparam int AUDIO_SAMPLES = 6;

  logic               clk_28;
  logic               pll_locked;
  logic               key_reset;
  logic               sw_exchan;
  logic               sw_mix;
  logic [AUDIO_W-1:0] left_sample;
  logic [AUDIO_W-1:0] right_sample;
  logic               sample_valid;
  logic [TRACK_W-1:0] track;
  logic               floppy_wr;
  logic               floppy_rd;
  logic               hd_wr;
  logic               hd_rd;
  logic               aud_bclk;
  logic               aud_lrck;
  logic               aud_dacdat;
  logic               sample_dropped;
  logic [SEG_W-1:0]   hex0;
  logic [SEG_W-1:0]   hex1;
  logic [LED_W-1:0]   led_g;

  logic [FRAME_BITS-1:0] rx_q[$];                                // Frames seen on the line
  logic [FRAME_BITS-1:0] exp_q[$];                               // Frames still expected
  logic [31:0]           rng_state = 32'hb398;
  int                    error_cnt = 0;
  int                    drop_cnt  = 0;

  de2_glue_top i_dut (
    .clk_28(clk_28), .pll_locked(pll_locked), .key_reset(key_reset),
    .sw_exchan(sw_exchan), .sw_mix(sw_mix),
    .left_sample(left_sample), .right_sample(right_sample), .sample_valid(sample_valid),
    .track(track), .floppy_wr(floppy_wr), .floppy_rd(floppy_rd),
    .hd_wr(hd_wr), .hd_rd(hd_rd),
    .aud_bclk(aud_bclk), .aud_lrck(aud_lrck), .aud_dacdat(aud_dacdat),
    .sample_dropped(sample_dropped), .hex0(hex0), .hex1(hex1), .led_g(led_g)
  );

  initial begin
    clk_28 = 1'b0;
    forever #CLK_HALF clk_28 = ~clk_28;
  end

  //////////////////////////////////////////////////
  // Codec capture and drop counter
  //////////////////////////////////////////////////
  initial begin : codec_capture
    logic                  prev_lrck;
    logic                  synced;                              // Seen a frame start
    int                    bit_idx;
    logic [FRAME_BITS-1:0] word;
    prev_lrck = 1'b0;
    synced    = 1'b0;
    bit_idx   = 0;
    word      = '0;
    forever begin
      @(posedge aud_bclk);                                       // Receiver sample point
      if (prev_lrck && !aud_lrck) begin
        synced  = 1'b1;                                          // Left slot, first bit
        bit_idx = 0;
      end
      if (synced) begin
        word    = {word[FRAME_BITS-2:0], aud_dacdat};
        bit_idx = bit_idx + 1;
        if (bit_idx == FRAME_BITS) begin
          rx_q.push_back(word);
        end
      end
      prev_lrck = aud_lrck;
    end
  end

  always @(posedge clk_28) begin
    if (sample_dropped === 1'b1) begin
      drop_cnt++;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk_28);
    $display("Run timed out after %0d cycles, the tests did not finish", WATCHDOG_CYC);
    $display("Finished with errors");
    $finish;
  end

  //////////////////////////////////////////////////
  // Models and helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Standard hex glyphs, lit segments with bit 0 = a, driven active low
  function automatic logic [SEG_W-1:0] seg_glyph(input logic [3:0] nib);
    logic [6:0] on;
    case (nib)
      4'h0:    on = 7'h3f;
      4'h1:    on = 7'h06;
      4'h2:    on = 7'h5b;
      4'h3:    on = 7'h4f;
      4'h4:    on = 7'h66;
      4'h5:    on = 7'h6d;
      4'h6:    on = 7'h7d;
      4'h7:    on = 7'h07;
      4'h8:    on = 7'h7f;
      4'h9:    on = 7'h6f;
      4'ha:    on = 7'h77;
      4'hb:    on = 7'h7c;
      4'hc:    on = 7'h39;
      4'hd:    on = 7'h5e;
      4'he:    on = 7'h79;
      default: on = 7'h71;
    endcase
    return ~on;
  endfunction

  // Own minus a quarter of itself plus a quarter of the other, no saturation
  function automatic logic [AUDIO_W-1:0] quarter_mix(input logic [AUDIO_W-1:0] own,
                                                     input logic [AUDIO_W-1:0] other);
    int o;
    int t;
    o = $signed(own);
    t = $signed(other);
    return AUDIO_W'(o - (o >>> 2) + (t >>> 2));
  endfunction

  function automatic logic [FRAME_BITS-1:0] slot_pair(input logic [AUDIO_W-1:0] l,
                                                      input logic [AUDIO_W-1:0] r);
    return {l, 1'b0, r, 1'b0};                                   // Sample then zero pad
  endfunction

  function automatic int count_frames(input bit nonzero_only);
    int n;
    n = 0;
    foreach (rx_q[i]) begin
      if (!nonzero_only || rx_q[i] !== '0) n++;
    end
    return n;
  endfunction

  task automatic step(input int n);
    repeat (n) @(posedge clk_28);
    #1;                                                          // Drive after the edge
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      error_cnt++;
    end
  endtask

  task automatic report(input string name, input int err0);
    $display("%-14s %s, %0d errors", name, (error_cnt == err0) ? "ok" : "FAILED",
             error_cnt - err0);
  endtask

  task automatic draw_pair(output logic [AUDIO_W-1:0] l, output logic [AUDIO_W-1:0] r);
    do begin
      rng_state = xorshift(rng_state);
      l = rng_state[AUDIO_W-1:0];
      r = rng_state[AUDIO_W+15:16];
    end while ({l, r} == '0);                                    // Keep frames visible
  endtask

  task automatic wait_frames(input string name, input int n, input bit nonzero_only);
    int waited;
    waited = 0;
    while (count_frames(nonzero_only) < n && waited < MAX_FRAMES * FRAME_CYCLES) begin
      step(1);
      waited++;
    end
    if (count_frames(nonzero_only) < n) begin
      $display("%s: only %0d of %0d codec frames arrived in time", name,
               count_frames(nonzero_only), n);
      error_cnt++;
    end
  endtask

  task automatic compare_frames(input string name);
    logic [FRAME_BITS-1:0] got;
    while (exp_q.size() > 0 && rx_q.size() > 0) begin
      got = rx_q.pop_front();
      if (got !== '0) check(name, exp_q.pop_front(), got);       // Skip silence
    end
    if (exp_q.size() > 0) begin
      $display("%s: %0d expected frames never reached the codec", name, exp_q.size());
      error_cnt++;
      exp_q.delete();
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic reset_state();
    int err0;
    err0 = error_cnt;
    step(RESET_CYCLES - 1);                                      // Still in reset
    check("reset_state", 3'b000, {aud_bclk, aud_lrck, aud_dacdat});
    check("reset_state", 0, led_g);
    check("reset_state", 0, sample_dropped);
    step(1);
    pll_locked = 1'b1;                                           // Lock after 3 cycles
    step(SYNC_STAGES + 1);                                       // Internal reset just released
    check("reset_state", 3'b000, {aud_bclk, aud_lrck, aud_dacdat});
    check("reset_state", 0, led_g);
    check("reset_state", 0, sample_dropped);
    step(2);
    check("reset_state", seg_glyph(4'h0), hex0);                 // Track 00
    check("reset_state", seg_glyph(4'h0), hex1);
    wait_frames("reset_state", 3, 1'b0);
    foreach (rx_q[i]) check("reset_state", '0, rx_q[i]);         // Silence only
    rx_q.delete();
    report("reset_state", err0);
  endtask

  task automatic track_digits();
    int err0;
    err0 = error_cnt;
    for (int i = 0; i < 8; i++) begin
      rng_state = xorshift(rng_state);
      track     = rng_state[TRACK_W-1:0];
      step(3);                                                   // Sample plus decode
      check("track_digits", seg_glyph(track[3:0]), hex0);
      check("track_digits", seg_glyph(track[7:4]), hex1);
    end
    report("track_digits", err0);
  endtask

  task automatic activity_stretch();
    int err0;
    err0 = error_cnt;
    floppy_rd = 1'b1;
    step(1);
    floppy_rd = 1'b0;
    step(ACT_HOLD_TICKS * TICK_DIV - 6);                         // Short of the hold
    check("activity", 4'b0010, led_g);                           // floppy_rd LED only
    step(2 * TICK_DIV + 4);                                      // Past hold plus a tick
    check("activity", 4'b0000, led_g);
    report("activity", err0);
  endtask

  task automatic audio_path(input string name, input logic exchan, input logic mix);
    int                    err0;
    logic [AUDIO_W-1:0]    l;
    logic [AUDIO_W-1:0]    r;
    logic [AUDIO_W-1:0]    el;
    logic [AUDIO_W-1:0]    er;
    logic [FRAME_BITS-1:0] expected;
    err0      = error_cnt;
    sw_exchan = exchan;
    sw_mix    = mix;
    step(SYNC_STAGES + 2);                                       // Switches synced
    rx_q.delete();
    exp_q.delete();
    for (int i = 0; i < AUDIO_SAMPLES; i++) begin
      do begin
        draw_pair(l, r);
        el       = exchan ? r : l;
        er       = exchan ? l : r;
        expected = mix ? slot_pair(quarter_mix(el, er), quarter_mix(er, el))
                       : slot_pair(el, er);
      end while (expected == '0);
      exp_q.push_back(expected);
      left_sample  = l;
      right_sample = r;
      sample_valid = 1'b1;
      step(1);
      sample_valid = 1'b0;
      step(FRAME_CYCLES - 1);                                    // One per codec frame
    end
    wait_frames(name, AUDIO_SAMPLES, 1'b1);
    compare_frames(name);
    report(name, err0);
  endtask

  task automatic back_pressure();
    int                 err0;
    logic [AUDIO_W-1:0] l;
    logic [AUDIO_W-1:0] r;
    err0      = error_cnt;
    sw_exchan = 1'b0;
    sw_mix    = 1'b0;
    step(SYNC_STAGES + 2);
    @(negedge aud_lrck);                                         // Just past a boundary
    step(1);
    rx_q.delete();
    exp_q.delete();
    drop_cnt = 0;
    for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
      draw_pair(l, r);
      if (i < FIFO_DEPTH) exp_q.push_back(slot_pair(l, r));      // Rest find no credit
      left_sample  = l;
      right_sample = r;
      sample_valid = 1'b1;
      step(1);
    end
    sample_valid = 1'b0;
    step(4);
    check("back_pressure", 3, drop_cnt);
    wait_frames("back_pressure", FIFO_DEPTH, 1'b1);
    compare_frames("back_pressure");
    report("back_pressure", err0);
  endtask

  initial begin
    pll_locked   = 1'b0;                                         // In reset from time 0
    key_reset    = 1'b1;
    sw_exchan    = 1'b0;
    sw_mix       = 1'b0;
    left_sample  = '0;
    right_sample = '0;
    sample_valid = 1'b0;
    track        = '0;
    floppy_wr    = 1'b0;
    floppy_rd    = 1'b0;
    hd_wr        = 1'b0;
    hd_rd        = 1'b0;
    reset_state();
    track_digits();
    activity_stretch();
    audio_path("straight", 1'b0, 1'b0);
    audio_path("swap", 1'b1, 1'b0);
    audio_path("swap_mix", 1'b1, 1'b1);
    back_pressure();
    $display("Tests run: %0d, errors: %0d", NUM_TESTS, error_cnt);
    if (error_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* test/tb_de2_glue_asserts.sv */
`timescale 1ns/1ps

module tb_de2_glue_asserts
  import board_pkg::*;
(
  input logic                clk_28,
  input logic                sys_rst_n,
  input logic [CREDIT_W-1:0] credit_cnt,    // Mixer credit counter
  input logic                frame_pop,
  input logic                tick_7,
  input logic                aud_bclk,
  input logic                aud_lrck
);

  //////////////////////////////////////////////////
  // Handshake rules
  //////////////////////////////////////////////////
  credit_bound: assert property (@(posedge clk_28) disable iff (!sys_rst_n)
    credit_cnt <= CREDIT_W'(FIFO_DEPTH))                  // Never more than slots
    else $error("credit count above FIFO depth");

  pop_needs_avail: assert property (@(posedge clk_28) disable iff (!sys_rst_n)
    frame_pop |-> (credit_cnt != CREDIT_W'(FIFO_DEPTH)))  // Popped frame still owns a credit
    else $error("frame_pop with no frame in the buffer");

  //////////////////////////////////////////////////
  // Timing rules
  //////////////////////////////////////////////////
  tick_single: assert property (@(posedge clk_28) disable iff (!sys_rst_n)
    tick_7 |=> !tick_7)                                   // One-cycle pulse
    else $error("tick_7 high in two consecutive cycles");

  lrck_on_fall: assert property (@(posedge clk_28) disable iff (!sys_rst_n)
    $changed(aud_lrck) |-> $fell(aud_bclk))               // Word clock moves with bclk fall
    else $error("aud_lrck changed away from a falling bit-clock edge");

endmodule

bind de2_glue_top tb_de2_glue_asserts i_asserts (
  .clk_28      (clk_28),
  .sys_rst_n   (sys_rst_n),
  .credit_cnt  (i_mixer.credit_cnt),
  .frame_pop   (frame_pop),
  .tick_7      (tick_7),
  .aud_bclk    (aud_bclk),
  .aud_lrck    (aud_lrck)
);

/* hw/de2_glue_top.sv */
`timescale 1ns/1ps

module de2_glue_top
  import board_pkg::*;
(
  input  logic               clk_28,
  input  logic               pll_locked,      // Async, active low
  input  logic               key_reset,       // Active low
  input  logic               sw_exchan,
  input  logic               sw_mix,
  input  logic [AUDIO_W-1:0] left_sample,
  input  logic [AUDIO_W-1:0] right_sample,
  input  logic               sample_valid,
  input  logic [TRACK_W-1:0] track,
  input  logic               floppy_wr,
  input  logic               floppy_rd,
  input  logic               hd_wr,
  input  logic               hd_rd,
  output logic               aud_bclk,
  output logic               aud_lrck,
  output logic               aud_dacdat,
  output logic               sample_dropped,
  output logic [SEG_W-1:0]   hex0,
  output logic [SEG_W-1:0]   hex1,
  output logic [LED_W-1:0]   led_g
);

  logic               sys_rst_n;
  logic               tick_7;
  logic               cfg_exchan;
  logic               cfg_mix;
  logic               frame_push;             // Mixer to buffer
  logic [AUDIO_W-1:0] frame_left;
  logic [AUDIO_W-1:0] frame_right;
  logic               credit_return;          // Buffer to mixer
  logic               frame_avail;            // Buffer to serializer
  logic               frame_pop;
  logic [AUDIO_W-1:0] pop_left;
  logic [AUDIO_W-1:0] pop_right;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////
  board_ctrl i_ctrl (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .key_reset  (key_reset),
    .sw_exchan  (sw_exchan),
    .sw_mix     (sw_mix),
    .sys_rst_n  (sys_rst_n),
    .tick_7     (tick_7),
    .cfg_exchan (cfg_exchan),
    .cfg_mix    (cfg_mix)
  );

  //////////////////////////////////////////////////
  // Audio path
  //////////////////////////////////////////////////
  audio_mixer i_mixer (
    .clk_28         (clk_28),
    .sys_rst_n      (sys_rst_n),
    .cfg_exchan     (cfg_exchan),
    .cfg_mix        (cfg_mix),
    .left_sample    (left_sample),
    .right_sample   (right_sample),
    .sample_valid   (sample_valid),
    .credit_return  (credit_return),
    .frame_push     (frame_push),
    .frame_left     (frame_left),
    .frame_right    (frame_right),
    .sample_dropped (sample_dropped)
  );

  frame_fifo i_fifo (
    .clk_28        (clk_28),
    .sys_rst_n     (sys_rst_n),
    .frame_push    (frame_push),
    .frame_left    (frame_left),
    .frame_right   (frame_right),
    .frame_pop     (frame_pop),
    .frame_avail   (frame_avail),
    .pop_left      (pop_left),
    .pop_right     (pop_right),
    .credit_return (credit_return)
  );

  i2s_serializer i_ser (
    .clk_28      (clk_28),
    .sys_rst_n   (sys_rst_n),
    .frame_avail (frame_avail),
    .pop_left    (pop_left),
    .pop_right   (pop_right),
    .frame_pop   (frame_pop),
    .aud_bclk    (aud_bclk),
    .aud_lrck    (aud_lrck),
    .aud_dacdat  (aud_dacdat)
  );

  // Indicators
  track_display i_disp (
    .clk_28    (clk_28),
    .sys_rst_n (sys_rst_n),
    .tick_7    (tick_7),
    .track     (track),
    .floppy_wr (floppy_wr),
    .floppy_rd (floppy_rd),
    .hd_wr     (hd_wr),
    .hd_rd     (hd_rd),
    .hex0      (hex0),
    .hex1      (hex1),
    .led_g     (led_g)
  );

endmodule

/* hw/track_display.sv */
`timescale 1ns/1ps

module track_display
  import board_pkg::*;
(
  input  logic               clk_28,
  input  logic               sys_rst_n,
  input  logic               tick_7,          // Hold counter pace
  input  logic [TRACK_W-1:0] track,           // Floppy track number
  input  logic               floppy_wr,
  input  logic               floppy_rd,
  input  logic               hd_wr,
  input  logic               hd_rd,
  output logic [SEG_W-1:0]   hex0,            // Low nibble
  output logic [SEG_W-1:0]   hex1,            // High nibble
  output logic [LED_W-1:0]   led_g
);

  logic [TRACK_W-1:0] track_q;
  logic [LED_W-1:0]   act;                    // Activity pulses
  logic [ACT_W-1:0]   hold_cnt [LED_W];       // Remaining lit ticks
  logic [LED_W-1:0]   lit;

  //////////////////////////////////////////////////
  // Track digits
  //////////////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    track_q <= track;                          // Sample the core's value
  end

  always_ff @(posedge clk_28 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      hex0 <= SEG_BLANK;                       // Dark until first sample
      hex1 <= SEG_BLANK;
    end else begin
      hex0 <= seg_hex(track_q[3:0]);
      hex1 <= seg_hex(track_q[7:4]);
    end
  end

  //////////////////////////////////////////////////
  // Activity stretch
  //////////////////////////////////////////////////
  assign act = {hd_rd, hd_wr, floppy_rd, floppy_wr};  // Bit 0 is floppy_wr

  always_ff @(posedge clk_28 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      for (int i = 0; i < LED_W; i++) begin
        hold_cnt[i] <= '0;
      end
      led_g <= '0;
    end else begin
      for (int i = 0; i < LED_W; i++) begin
        if (act[i]) begin
          hold_cnt[i] <= ACT_W'(ACT_HOLD_TICKS);  // Retrigger
        end else if (tick_7 && (hold_cnt[i] != '0)) begin
          hold_cnt[i] <= hold_cnt[i] - 1'b1;      // Count down on tick
        end
      end
      led_g <= lit;
    end
  end

  always_comb begin
    for (int i = 0; i < LED_W; i++) begin
      lit[i] = (hold_cnt[i] != '0);            // Lit while holding
    end
  end

endmodule

/* hw/i2s_serializer.sv */
`timescale 1ns/1ps

module i2s_serializer
  import board_pkg::*;
(
  input  logic               clk_28,
  input  logic               sys_rst_n,
  input  logic               frame_avail,
  input  logic [AUDIO_W-1:0] pop_left,
  input  logic [AUDIO_W-1:0] pop_right,
  output logic               frame_pop,       // Take head frame
  output logic               aud_bclk,
  output logic               aud_lrck,        // Low left, high right
  output logic               aud_dacdat
);

  logic [BCLK_W-1:0]     bclk_cnt;            // Phase in bit-clock period
  logic [BIT_W-1:0]      bit_cnt;             // Bit position in frame
  logic [BIT_W-1:0]      bit_next;
  logic [FRAME_BITS-1:0] shift_reg;
  logic [FRAME_BITS-1:0] load_word;           // Next frame, padded
  logic                  bclk_fall;           // bclk drops at this edge
  logic                  bclk_rise;
  logic                  last_bit;
  logic                  boundary;            // Frame starts at this edge

  assign bclk_fall = (bclk_cnt == BCLK_W'(BCLK_DIV - 1));
  assign bclk_rise = (bclk_cnt == BCLK_W'(BCLK_DIV / 2 - 1));
  assign last_bit  = (bit_cnt == BIT_W'(FRAME_BITS - 1));
  assign boundary  = bclk_fall & last_bit;
  assign bit_next  = last_bit ? '0 : bit_cnt + 1'b1;

  assign frame_pop = boundary & frame_avail;  // Data read at same edge

  // Sample MSB first, zero pad behind it; silence when buffer is empty
  always_comb begin
    if (frame_avail) begin
      load_word = {pop_left,  {(SLOT_W - AUDIO_W){1'b0}},
                   pop_right, {(SLOT_W - AUDIO_W){1'b0}}};
    end else begin
      load_word = '0;
    end
  end

  //////////////////////////////////////////////////
  // Bit clock and frame counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bclk_cnt   <= '0;
      bit_cnt    <= BIT_W'(FRAME_BITS - 1);  // First fall opens a frame
      aud_bclk   <= 1'b0;
      aud_lrck   <= 1'b0;
      aud_dacdat <= 1'b0;
    end else begin
      bclk_cnt <= bclk_fall ? '0 : bclk_cnt + 1'b1;
      if (bclk_rise) begin
        aud_bclk <= 1'b1;                    // Second half high
      end else if (bclk_fall) begin
        aud_bclk   <= 1'b0;
        bit_cnt    <= bit_next;
        aud_lrck   <= (bit_next >= BIT_W'(SLOT_W));      // Right slot
        aud_dacdat <= boundary ? load_word[FRAME_BITS-1] : shift_reg[FRAME_BITS-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // Shift register
  //////////////////////////////////////////////////
  always_ff @(posedge clk_28) begin
    if (boundary) begin
      shift_reg <= {load_word[FRAME_BITS-2:0], 1'b0};   // MSB already on line
    end else if (bclk_fall) begin
      shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
    end
  end

endmodule

/* hw/frame_fifo.sv */
`timescale 1ns/1ps

module frame_fifo
  import board_pkg::*;
(
  input  logic               clk_28,
  input  logic               sys_rst_n,
  input  logic               frame_push,      // Only with a credit
  input  logic [AUDIO_W-1:0] frame_left,
  input  logic [AUDIO_W-1:0] frame_right,
  input  logic               frame_pop,       // Only while frame_avail
  output logic               frame_avail,
  output logic [AUDIO_W-1:0] pop_left,        // Valid with frame_pop
  output logic [AUDIO_W-1:0] pop_right,
  output logic               credit_return    // One pulse per pop
);

  logic [AUDIO_W-1:0]  mem_left  [FIFO_DEPTH];
  logic [AUDIO_W-1:0]  mem_right [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CREDIT_W-1:0] count;                 // Occupancy

  // Frame storage
  always_ff @(posedge clk_28) begin
    if (frame_push) begin
      mem_left[wr_ptr]  <= frame_left;
      mem_right[wr_ptr] <= frame_right;
    end
  end

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (frame_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (frame_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (frame_push && !frame_pop) begin
        count <= count + 1'b1;
      end else if (frame_pop && !frame_push) begin
        count <= count - 1'b1;
      end
      credit_return <= frame_pop;             // Slot freed, tell the mixer
    end
  end

  assign frame_avail = (count != '0);
  assign pop_left    = mem_left[rd_ptr];      // Head of buffer
  assign pop_right   = mem_right[rd_ptr];

endmodule

/* hw/audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer
  import board_pkg::*;
(
  input  logic               clk_28,
  input  logic               sys_rst_n,
  input  logic               cfg_exchan,      // Swap channels
  input  logic               cfg_mix,         // Centered mix
  input  logic [AUDIO_W-1:0] left_sample,     // Signed
  input  logic [AUDIO_W-1:0] right_sample,    // Signed
  input  logic               sample_valid,    // One-cycle strobe
  input  logic               credit_return,   // One credit back from buffer
  output logic               frame_push,
  output logic [AUDIO_W-1:0] frame_left,
  output logic [AUDIO_W-1:0] frame_right,
  output logic               sample_dropped   // Sample found no credit
);

  logic signed [AUDIO_W-1:0] own_l;           // After optional swap
  logic signed [AUDIO_W-1:0] own_r;
  logic signed [AUDIO_W-1:0] mix_l;           // Quarter-mixed
  logic signed [AUDIO_W-1:0] mix_r;
  logic [CREDIT_W-1:0]       credit_cnt;      // Free buffer slots
  logic                      has_credit;
  logic                      take;            // Sample accepted this cycle

  //////////////////////////////////////////////////
  // Swap and mix
  //////////////////////////////////////////////////
  always_comb begin
    if (cfg_exchan) begin
      own_l = $signed(right_sample);
      own_r = $signed(left_sample);
    end else begin
      own_l = $signed(left_sample);
      own_r = $signed(right_sample);
    end
  end

  // Three quarters own plus one quarter other, stays in range
  assign mix_l = own_l - (own_l >>> MIX_SHIFT) + (own_r >>> MIX_SHIFT);
  assign mix_r = own_r - (own_r >>> MIX_SHIFT) + (own_l >>> MIX_SHIFT);

  //////////////////////////////////////////////////
  // Credit counter
  //////////////////////////////////////////////////
  assign has_credit = (credit_cnt != '0);
  assign take       = sample_valid & has_credit;

  always_ff @(posedge clk_28 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      credit_cnt     <= CREDIT_W'(FIFO_DEPTH);  // Buffer starts empty
      frame_push     <= 1'b0;
      sample_dropped <= 1'b0;
    end else begin
      if (take && !credit_return) begin
        credit_cnt <= credit_cnt - 1'b1;        // Spend one
      end else if (!take && credit_return) begin
        credit_cnt <= credit_cnt + 1'b1;        // Got one back
      end
      frame_push     <= take;
      sample_dropped <= sample_valid & ~has_credit;
    end
  end

  // Frame payload
  always_ff @(posedge clk_28) begin
    if (take) begin
      frame_left  <= cfg_mix ? mix_l : own_l;
      frame_right <= cfg_mix ? mix_r : own_r;
    end
  end

endmodule

/* hw/board_ctrl.sv */
`timescale 1ns/1ps

module board_ctrl
  import board_pkg::*;
(
  input  logic clk_28,
  input  logic pll_locked,                // Async, active low
  input  logic key_reset,                 // Reset key, active low
  input  logic sw_exchan,                 // Raw switch
  input  logic sw_mix,                    // Raw switch
  output logic sys_rst_n,                 // Internal reset, sync release
  output logic tick_7,                    // One pulse every TICK_DIV cycles
  output logic cfg_exchan,
  output logic cfg_mix
);

  logic                         rst_arst_n;   // PLL lock and key combined
  logic [SYNC_STAGES-1:0]       rst_sync;     // Reset release chain
  logic [SYNC_STAGES-1:0][1:0]  sw_sync;      // Switch chain, {mix, exchan}
  logic [TICK_W-1:0]            tick_cnt;
  logic                         tick_wrap;

  //////////////////////////////////////////////////
  // Reset release
  //////////////////////////////////////////////////
  assign rst_arst_n = pll_locked & key_reset;  // Either one holds reset

  // Assert at once, release after SYNC_STAGES edges
  always_ff @(posedge clk_28 or negedge rst_arst_n) begin
    if (!rst_arst_n) begin
      rst_sync <= '0;
    end else begin
      rst_sync <= {rst_sync[SYNC_STAGES-2:0], 1'b1};  // Shift ones in
    end
  end

  assign sys_rst_n = rst_sync[SYNC_STAGES-1];  // Last stage

  //////////////////////////////////////////////////
  // Switch synchronizers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      sw_sync <= '0;
    end else begin
      sw_sync <= {sw_sync[SYNC_STAGES-2:0], {sw_mix, sw_exchan}};
    end
  end

  // Configuration decode
  assign cfg_exchan = sw_sync[SYNC_STAGES-1][0];  // Swap left and right
  assign cfg_mix    = sw_sync[SYNC_STAGES-1][1];  // Centered mix

  //////////////////////////////////////////////////
  // Quarter-rate tick
  //////////////////////////////////////////////////
  assign tick_wrap = (tick_cnt == TICK_W'(TICK_DIV - 1));

  always_ff @(posedge clk_28 or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tick_cnt <= TICK_W'(TICK_INIT);     // Same phase as old 7 MHz divider
      tick_7   <= 1'b0;
    end else begin
      tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
      tick_7   <= tick_wrap;               // Registered pulse
    end
  end

endmodule

/* hw/board_pkg.sv */
package board_pkg;

  //////////////////////////////////////////////////
  // Audio path
  //////////////////////////////////////////////////
  localparam int AUDIO_W    = 15;                      // Core sample width
  localparam int SLOT_W     = 16;                      // Codec slot, sample plus zero pad
  localparam int FRAME_BITS = 2 * SLOT_W;              // Left slot then right slot
  localparam int BIT_W      = $clog2(FRAME_BITS);      // Bit position in frame
  localparam int MIX_SHIFT  = 2;                       // Quarter of the other channel
  localparam int FIFO_DEPTH = 4;                       // Frames, also initial credits
  localparam int PTR_W      = $clog2(FIFO_DEPTH);      // Buffer pointer width
  localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);  // Holds 0..FIFO_DEPTH
  localparam int BCLK_DIV   = 4;                       // clk_28 cycles per bit clock
  localparam int BCLK_W     = $clog2(BCLK_DIV);

  //////////////////////////////////////////////////
  // Board control and indicators
  //////////////////////////////////////////////////
  localparam int SYNC_STAGES    = 2;                       // Two-flop synchronizers
  localparam int TICK_DIV       = 4;                       // Quarter-rate tick
  localparam int TICK_W         = $clog2(TICK_DIV);
  localparam int TICK_INIT      = 2;                       // Counter value out of reset
  localparam int ACT_HOLD_TICKS = 16;                      // LED stretch in ticks
  localparam int ACT_W          = $clog2(ACT_HOLD_TICKS + 1);
  localparam int LED_W          = 4;                       // Floppy wr/rd, hd wr/rd
  localparam int TRACK_W        = 8;
  localparam int SEG_W          = 7;                       // Segments g..a
  localparam logic [SEG_W-1:0] SEG_BLANK = 7'h7f;          // All off, active low

  // Nibble to active-low segment pattern, bit 6 = g, bit 0 = a
  function automatic logic [SEG_W-1:0] seg_hex(input logic [3:0] nib);
    logic [SEG_W-1:0] seg;
    case (nib)
      4'h0:    seg = 7'h40;
      4'h1:    seg = 7'h79;
      4'h2:    seg = 7'h24;
      4'h3:    seg = 7'h30;
      4'h4:    seg = 7'h19;
      4'h5:    seg = 7'h12;
      4'h6:    seg = 7'h02;
      4'h7:    seg = 7'h78;
      4'h8:    seg = 7'h00;
      4'h9:    seg = 7'h10;
      4'ha:    seg = 7'h08;
      4'hb:    seg = 7'h03;               // Lower case b
      4'hc:    seg = 7'h46;
      4'hd:    seg = 7'h21;               // Lower case d
      4'he:    seg = 7'h06;
      default: seg = 7'h0e;               // F
    endcase
    return seg;
  endfunction

endpackage
